//--- common/vseq_pkg.sv
// Sizes and shared types of the vector instruction sequencer
// ID and mask widths are fixed here, so NR_VINSN in the RTL must not exceed NrVInsn
// Field widths of the structs follow from the sizes below

package vseq_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  // Instruction IDs that may be in flight at once
  localparam int unsigned NrVInsn = 8;
  // Architectural vector registers
  localparam int unsigned NrVRegs = 32;
  // Functional unit classes
  localparam int unsigned NrUnits = 4;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;
  // One bit per instruction ID
  typedef logic [NrVInsn-1:0] vid_mask_t;

  // Unit classes, encoding doubles as row index in the tracker and credit logic
  typedef enum logic [1:0] {
    UNIT_ALU   = 2'd0,
    UNIT_MUL   = 2'd1,
    UNIT_LOAD  = 2'd2,
    UNIT_STORE = 2'd3
  } unit_e;

  ////////////////////////////////////////////////////////////
  // Requests and responses
  ////////////////////////////////////////////////////////////

  // Decoded instruction from the dispatcher
  typedef struct packed {
    unit_e unit;
    vreg_t vd;
    vreg_t vs1;
    vreg_t vs2;
    logic  use_vd;
    logic  use_vs1;
    logic  use_vs2;
  } seq_req_t;

  // Issued instruction towards the units, with its ID and hazard sets
  typedef struct packed {
    unit_e     unit;
    vreg_t     vd;
    vreg_t     vs1;
    vreg_t     vs2;
    logic      use_vd;
    logic      use_vs1;
    logic      use_vs2;
    vid_t      id;
    vid_mask_t hazard_vs1;
    vid_mask_t hazard_vs2;
    vid_mask_t hazard_vd;
  } pe_req_t;

  // Done flags, one ID mask per unit class, indexed by unit_e
  typedef vid_mask_t [NrUnits-1:0] unit_done_t;

endpackage

//--- design/vinsn_tracker.sv
// Running-instruction matrix, one ID row per unit class
// Only IDs below NR_VINSN are handed out, upper mask bits stay zero
// Done pulses on IDs that are not running in that unit have no effect

`timescale 1ns/100ps

module vinsn_tracker #(
  parameter int unsigned NR_VINSN = vseq_pkg::NrVInsn
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 accept_i,
  input  vseq_pkg::unit_e      accept_unit_i,
  input  vseq_pkg::unit_done_t unit_done_i,
  output vseq_pkg::vid_t       free_id_o,
  output logic                 id_full_o,
  output vseq_pkg::vid_mask_t  running_o,
  output logic                 idle_o
);
  import vseq_pkg::*;

  // Set bit means the ID runs on that unit class
  vid_mask_t [NrUnits-1:0] running_d, running_q;

  // Merge all rows into one running vector
  always_comb begin : p_running
    running_o = '0;
    for (int u = 0; u < NrUnits; u++) begin
      running_o |= running_q[u];
    end
  end

  // Lowest free ID wins, scan from the top so the last hit is the smallest
  always_comb begin : p_free_id
    free_id_o = '0;
    for (int i = NR_VINSN - 1; i >= 0; i--) begin
      if (!running_o[i]) begin
        free_id_o = vid_t'(i);
      end
    end
  end

  assign id_full_o = &running_o[NR_VINSN-1:0];
  assign idle_o    = ~|running_o;

  // Clear on done first, then set on issue
  always_comb begin : p_next
    for (int u = 0; u < NrUnits; u++) begin
      running_d[u] = running_q[u] & ~unit_done_i[u];
      if (accept_i && (accept_unit_i == unit_e'(u))) begin
        running_d[u][free_id_o] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_running_ff
    if (!rst_ni) begin
      running_q <= '0;
    end else begin
      running_q <= running_d;
    end
  end

  // Issue logic must stall once every ID is taken
  a_no_accept_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept_i |-> !id_full_o);

endmodule

//--- design/unit_credit.sv
// Instruction queue occupancy per unit class
// Any done pulse of a unit frees one slot, at most one completion per unit per cycle
// A unit is ready while fewer than QUEUE_DEPTH of its instructions are counted

`timescale 1ns/100ps

module unit_credit #(
  parameter int unsigned QUEUE_DEPTH = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          accept_i,
  input  vseq_pkg::unit_e               accept_unit_i,
  input  vseq_pkg::unit_done_t          unit_done_i,
  output logic [vseq_pkg::NrUnits-1:0]  unit_ready_o
);
  import vseq_pkg::*;

  localparam int unsigned CntWidth = $clog2(QUEUE_DEPTH + 1);
  localparam logic [CntWidth-1:0] DepthMax = CntWidth'(QUEUE_DEPTH);

  logic [NrUnits-1:0][CntWidth-1:0] cnt_q;
  logic [NrUnits-1:0]               cnt_up;
  logic [NrUnits-1:0]               cnt_down;

  for (genvar u = 0; u < NrUnits; u++) begin : gen_unit_cnt
    // Issue to this unit
    assign cnt_up[u]   = accept_i && (accept_unit_i == unit_e'(u));
    // Done mask reduced to one count-down pulse
    assign cnt_down[u] = |unit_done_i[u];

    // Up and down in the same cycle cancel out
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt
      if (!rst_ni) begin
        cnt_q[u] <= '0;
      end else if (cnt_up[u] && !cnt_down[u]) begin
        cnt_q[u] <= cnt_q[u] + CntWidth'(1);
      end else if (cnt_down[u] && !cnt_up[u]) begin
        cnt_q[u] <= cnt_q[u] - CntWidth'(1);
      end
    end

    assign unit_ready_o[u] = (cnt_q[u] < DepthMax);

    // Issue gating keeps the count in range, completions only for counted work
    a_cnt_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (cnt_q[u] <= DepthMax) && !(cnt_down[u] && !cnt_up[u] && (cnt_q[u] == '0)));
  end

endmodule

//--- scoreboard/vreg_scoreboard.sv
// Per-register reader and writer lists with hazard extraction
// Only the latest reader and the latest writer of each register are kept
// An entry counts only while its ID is still marked running

`timescale 1ns/100ps

module vreg_scoreboard (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  vseq_pkg::seq_req_t  req_i,
  input  logic                accept_i,
  input  vseq_pkg::vid_t      accept_id_i,
  input  vseq_pkg::vid_mask_t running_i,
  output vseq_pkg::vid_mask_t hazard_vs1_o,
  output vseq_pkg::vid_mask_t hazard_vs2_o,
  output vseq_pkg::vid_mask_t hazard_vd_o
);
  import vseq_pkg::*;

  // Access record of one register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

  vreg_access_t [NrVRegs-1:0] read_list_d, read_list_q;
  vreg_access_t [NrVRegs-1:0] write_list_d, write_list_q;
  // Lists with retired IDs already dropped
  vreg_access_t [NrVRegs-1:0] read_live, write_live;

  ////////////////////////////////////////////////////////////
  // Retirement filter
  ////////////////////////////////////////////////////////////

  always_comb begin : p_live
    read_live  = read_list_q;
    write_live = write_list_q;
    for (int v = 0; v < NrVRegs; v++) begin
      read_live[v].valid  = read_list_q[v].valid & running_i[read_list_q[v].vid];
      write_live[v].valid = write_list_q[v].valid & running_i[write_list_q[v].vid];
    end
  end

  ////////////////////////////////////////////////////////////
  // Hazards of the request at the input
  ////////////////////////////////////////////////////////////

  always_comb begin : p_hazard
    hazard_vs1_o = '0;
    hazard_vs2_o = '0;
    hazard_vd_o  = '0;
    // RAW on the source operands
    if (req_i.use_vs1 && write_live[req_i.vs1].valid) begin
      hazard_vs1_o[write_live[req_i.vs1].vid] = 1'b1;
    end
    if (req_i.use_vs2 && write_live[req_i.vs2].valid) begin
      hazard_vs2_o[write_live[req_i.vs2].vid] = 1'b1;
    end
    // WAR blocks both operand paths
    if (req_i.use_vd && read_live[req_i.vd].valid) begin
      hazard_vs1_o[read_live[req_i.vd].vid] = 1'b1;
      hazard_vs2_o[read_live[req_i.vd].vid] = 1'b1;
    end
    // WAW on the destination
    if (req_i.use_vd && write_live[req_i.vd].valid) begin
      hazard_vd_o[write_live[req_i.vd].vid] = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // List update
  ////////////////////////////////////////////////////////////

  // vs1 equal to vs2 writes the same record twice
  always_comb begin : p_update
    read_list_d  = read_live;
    write_list_d = write_live;
    if (accept_i) begin
      if (req_i.use_vd) begin
        write_list_d[req_i.vd] = '{vid: accept_id_i, valid: 1'b1};
      end
      if (req_i.use_vs1) begin
        read_list_d[req_i.vs1] = '{vid: accept_id_i, valid: 1'b1};
      end
      if (req_i.use_vs2) begin
        read_list_d[req_i.vs2] = '{vid: accept_id_i, valid: 1'b1};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_list_ff
    if (!rst_ni) begin
      read_list_q  <= '0;
      write_list_q <= '0;
    end else begin
      read_list_q  <= read_list_d;
      write_list_q <= write_list_d;
    end
  end

  // The tracker must hand out an ID that no list entry can still own
  a_new_id_free : assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept_i |-> !running_i[accept_id_i]);

endmodule

//--- design/issue_ctrl.sv
// Accept decision and one-entry output register towards the units
// req_ready_o depends combinationally on req_i.unit and pe_ready_i
// The held request is replaced on the same edge that pe_ready_i retires it

`timescale 1ns/100ps

module issue_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Dispatcher side
  input  vseq_pkg::seq_req_t            req_i,
  input  logic                          req_valid_i,
  // Bookkeeping status
  input  vseq_pkg::vid_t                free_id_i,
  input  logic                          id_full_i,
  input  logic [vseq_pkg::NrUnits-1:0]  unit_ready_i,
  input  vseq_pkg::vid_mask_t           hazard_vs1_i,
  input  vseq_pkg::vid_mask_t           hazard_vs2_i,
  input  vseq_pkg::vid_mask_t           hazard_vd_i,
  // Unit side
  input  logic                          pe_ready_i,
  output logic                          accept_o,
  output logic                          req_ready_o,
  output vseq_pkg::pe_req_t             pe_req_o,
  output logic                          pe_req_valid_o
);
  import vseq_pkg::*;

  pe_req_t pe_req_d;
  // Output slot empty now or emptied at this edge
  logic    out_free;

  ////////////////////////////////////////////////////////////
  // Accept condition
  ////////////////////////////////////////////////////////////

  assign out_free    = !pe_req_valid_o || pe_ready_i;
  assign req_ready_o = !id_full_i && unit_ready_i[req_i.unit] && out_free;
  assign accept_o    = req_valid_i && req_ready_o;

  // Request plus its ID and hazard sets
  always_comb begin : p_build
    pe_req_d = '{
      unit       : req_i.unit,
      vd         : req_i.vd,
      vs1        : req_i.vs1,
      vs2        : req_i.vs2,
      use_vd     : req_i.use_vd,
      use_vs1    : req_i.use_vs1,
      use_vs2    : req_i.use_vs2,
      id         : free_id_i,
      hazard_vs1 : hazard_vs1_i,
      hazard_vs2 : hazard_vs2_i,
      hazard_vd  : hazard_vd_i
    };
  end

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid_ff
    if (!rst_ni) begin
      pe_req_valid_o <= 1'b0;
    end else if (accept_o) begin
      pe_req_valid_o <= 1'b1;
    end else if (pe_ready_i) begin
      pe_req_valid_o <= 1'b0;
    end
  end

  // Payload loads only on issue and holds under back-pressure
  always_ff @(posedge clk_i) begin : p_payload_ff
    if (accept_o) begin
      pe_req_o <= pe_req_d;
    end
  end

  // Units see a stable request until they take it
  a_hold_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_req_valid_o && !pe_ready_i |=> pe_req_valid_o && $stable(pe_req_o));

endmodule

//--- design/vseq_top.sv
// Vector instruction sequencer top level
// One request in flight at the output, NR_VINSN IDs, QUEUE_DEPTH entries per unit queue
// NR_VINSN is bounded by vseq_pkg::NrVInsn

`timescale 1ns/100ps

module vseq_top #(
  parameter int unsigned NR_VINSN    = vseq_pkg::NrVInsn,
  parameter int unsigned QUEUE_DEPTH = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Dispatcher side
  input  vseq_pkg::seq_req_t   req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  // Unit side
  output vseq_pkg::pe_req_t    pe_req_o,
  output logic                 pe_req_valid_o,
  input  logic                 pe_ready_i,
  input  vseq_pkg::unit_done_t unit_done_i,
  // Status
  output logic                 idle_o
);
  import vseq_pkg::*;

  // Tracker outputs
  vid_t              free_id;
  logic              id_full;
  vid_mask_t         running;
  // Per-unit queue room
  logic [NrUnits-1:0] unit_ready;
  // Hazard sets for the request at req_i
  vid_mask_t         hazard_vs1;
  vid_mask_t         hazard_vs2;
  vid_mask_t         hazard_vd;
  // Issue strobe shared by all bookkeeping blocks
  logic              accept;

  vinsn_tracker #(
    .NR_VINSN (NR_VINSN)
  ) i_tracker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .accept_i      (accept),
    .accept_unit_i (req_i.unit),
    .unit_done_i   (unit_done_i),
    .free_id_o     (free_id),
    .id_full_o     (id_full),
    .running_o     (running),
    .idle_o        (idle_o)
  );

  unit_credit #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_credit (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .accept_i      (accept),
    .accept_unit_i (req_i.unit),
    .unit_done_i   (unit_done_i),
    .unit_ready_o  (unit_ready)
  );

  vreg_scoreboard i_scoreboard (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .accept_i     (accept),
    .accept_id_i  (free_id),
    .running_i    (running),
    .hazard_vs1_o (hazard_vs1),
    .hazard_vs2_o (hazard_vs2),
    .hazard_vd_o  (hazard_vd)
  );

  issue_ctrl i_issue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .req_valid_i    (req_valid_i),
    .free_id_i      (free_id),
    .id_full_i      (id_full),
    .unit_ready_i   (unit_ready),
    .hazard_vs1_i   (hazard_vs1),
    .hazard_vs2_i   (hazard_vs2),
    .hazard_vd_i    (hazard_vd),
    .pe_ready_i     (pe_ready_i),
    .accept_o       (accept),
    .req_ready_o    (req_ready_o),
    .pe_req_o       (pe_req_o),
    .pe_req_valid_o (pe_req_valid_o)
  );

endmodule

//--- test/vseq_model.svh
// Reference model of the sequencer, included inside the testbench module body
// Needs vseq_pkg imported and NR_VINSN and QUEUE_DEPTH declared before the include
// Model state is the state right after the next rising edge once commit_edge has run

`ifndef VSEQ_MODEL_SVH
`define VSEQ_MODEL_SVH

// Running IDs per unit class and queue occupancy
vid_mask_t   m_run [NrUnits];
int unsigned m_cnt [NrUnits];
// Latest reader and writer per register
vid_t        m_rd_vid [NrVRegs];
bit          m_rd_val [NrVRegs];
vid_t        m_wr_vid [NrVRegs];
bit          m_wr_val [NrVRegs];
// Expected contents of the output register
bit          m_out_valid;
pe_req_t     m_out_req;

task automatic clear_model();
  for (int u = 0; u < NrUnits; u++) begin
    m_run[u] = '0;
    m_cnt[u] = 0;
  end
  for (int v = 0; v < NrVRegs; v++) begin
    m_rd_vid[v] = '0;
    m_rd_val[v] = 1'b0;
    m_wr_vid[v] = '0;
    m_wr_val[v] = 1'b0;
  end
  m_out_valid = 1'b0;
  m_out_req   = '0;
endtask

function automatic vid_mask_t running_ids();
  vid_mask_t r;
  r = '0;
  for (int u = 0; u < NrUnits; u++) begin
    r = r | m_run[u];
  end
  return r;
endfunction

function automatic bit ids_full();
  vid_mask_t r;
  r = running_ids();
  return &r[NR_VINSN-1:0];
endfunction

function automatic vid_t lowest_free_id();
  vid_mask_t r;
  r = running_ids();
  for (int i = 0; i < NR_VINSN; i++) begin
    if (!r[i]) begin
      return vid_t'(i);
    end
  end
  return '0;
endfunction

// List entry counts only while its owner still runs
function automatic bit entry_live(input bit val, input vid_t id);
  vid_mask_t r;
  r = running_ids();
  return val && r[id];
endfunction

function automatic bit predict_ready(input seq_req_t req, input bit pe_ready);
  return !ids_full() && (m_cnt[req.unit] < QUEUE_DEPTH) && (!m_out_valid || pe_ready);
endfunction

// Issued request with ID and RAW, WAR and WAW sets
function automatic pe_req_t predict_issue(input seq_req_t req);
  pe_req_t p;
  p         = '0;
  p.unit    = req.unit;
  p.vd      = req.vd;
  p.vs1     = req.vs1;
  p.vs2     = req.vs2;
  p.use_vd  = req.use_vd;
  p.use_vs1 = req.use_vs1;
  p.use_vs2 = req.use_vs2;
  p.id      = lowest_free_id();
  // RAW
  if (req.use_vs1 && entry_live(m_wr_val[req.vs1], m_wr_vid[req.vs1])) begin
    p.hazard_vs1[m_wr_vid[req.vs1]] = 1'b1;
  end
  if (req.use_vs2 && entry_live(m_wr_val[req.vs2], m_wr_vid[req.vs2])) begin
    p.hazard_vs2[m_wr_vid[req.vs2]] = 1'b1;
  end
  // WAR lands on both source sets
  if (req.use_vd && entry_live(m_rd_val[req.vd], m_rd_vid[req.vd])) begin
    p.hazard_vs1[m_rd_vid[req.vd]] = 1'b1;
    p.hazard_vs2[m_rd_vid[req.vd]] = 1'b1;
  end
  // WAW
  if (req.use_vd && entry_live(m_wr_val[req.vd], m_wr_vid[req.vd])) begin
    p.hazard_vd[m_wr_vid[req.vd]] = 1'b1;
  end
  return p;
endfunction

// Advance the model over one rising edge
task automatic commit_edge(input bit accept, input seq_req_t req, input bit pe_ready,
                           input unit_done_t done);
  pe_req_t   p;
  vid_mask_t r;
  p = predict_issue(req);
  r = running_ids();
  // Retired owners drop out of the lists
  for (int v = 0; v < NrVRegs; v++) begin
    m_rd_val[v] = m_rd_val[v] && r[m_rd_vid[v]];
    m_wr_val[v] = m_wr_val[v] && r[m_wr_vid[v]];
  end
  for (int u = 0; u < NrUnits; u++) begin
    if (done[u] != '0) begin
      m_cnt[u] = m_cnt[u] - 1;
    end
    m_run[u] = m_run[u] & ~done[u];
  end
  if (accept) begin
    m_run[req.unit][p.id] = 1'b1;
    m_cnt[req.unit]       = m_cnt[req.unit] + 1;
    if (req.use_vd) begin
      m_wr_vid[req.vd] = p.id;
      m_wr_val[req.vd] = 1'b1;
    end
    if (req.use_vs1) begin
      m_rd_vid[req.vs1] = p.id;
      m_rd_val[req.vs1] = 1'b1;
    end
    if (req.use_vs2) begin
      m_rd_vid[req.vs2] = p.id;
      m_rd_val[req.vs2] = 1'b1;
    end
    m_out_req   = p;
    m_out_valid = 1'b1;
  end else if (pe_ready) begin
    m_out_valid = 1'b0;
  end
endtask

`endif

//--- test/tb_vseq_top.sv
// Random-stimulus testbench for the sequencer, checked cycle by cycle against a model
// Inputs change 10 ns after the rising edge, registered outputs are checked just before
// Combinational outputs are sampled at mid-cycle
// Register indices are kept to 0..7 so hazards occur often

`timescale 1ns/100ps

module tb_vseq_top;
  import vseq_pkg::*;

  // Fewer IDs than queue slots over all units, so ID exhaustion stalls on its own
  localparam int unsigned NR_VINSN     = 4;
  localparam int unsigned QUEUE_DEPTH  = 2;
  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned DRIVE_DELAY  = 10;
  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned NUM_CYCLES   = 2000;
  localparam int unsigned DRAIN_CYCLES = 200;

  logic       clk_i;
  logic       rst_ni;
  seq_req_t   req_i;
  logic       req_valid_i;
  logic       req_ready_o;
  pe_req_t    pe_req_o;
  logic       pe_req_valid_o;
  logic       pe_ready_i;
  unit_done_t unit_done_i;
  logic       idle_o;

  logic [31:0] rng_state;
  int unsigned errors;
  int unsigned checks;
  // Accepted requests not yet taken by the units
  pe_req_t     exp_q [$];
  // Dispatcher keeps its request while it waits for ready
  bit          req_hold;
  // Output was held under back-pressure in the previous cycle
  bit          hold_prev;
  pe_req_t     held_req;

  `include "vseq_model.svh"

  vseq_top #(
    .NR_VINSN    (NR_VINSN),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) uut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .pe_req_o       (pe_req_o),
    .pe_req_valid_o (pe_req_valid_o),
    .pe_ready_i     (pe_ready_i),
    .unit_done_i    (unit_done_i),
    .idle_o         (idle_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // One random ID out of the candidate set, or none
  function automatic vid_mask_t pick_done(input vid_mask_t cand, input logic [31:0] rnd);
    int        n;
    int        k;
    vid_mask_t one;
    one = '0;
    n   = $countones(cand);
    if (n == 0) begin
      return one;
    end
    k = int'(rnd % n);
    for (int i = 0; i < NrVInsn; i++) begin
      if (cand[i]) begin
        if (k == 0) begin
          one[i] = 1'b1;
        end
        k--;
      end
    end
    return one;
  endfunction

  // Drive one cycle, check the DUT and advance the model over the next edge
  task automatic run_cycle(input bit drain);
    logic [31:0] r;
    unit_done_t  done;
    vid_mask_t   cand;
    bit          pred_ready;
    bit          accept;
    @(posedge clk_i);
    #(DRIVE_DELAY);
    // Registered outputs after the edge
    check_value("pe_req_valid", 64'(m_out_valid), 64'(pe_req_valid_o));
    if (m_out_valid) begin
      check_value("pe_req", 64'(m_out_req), 64'(pe_req_o));
    end
    check_value("idle", 64'(running_ids() == '0), 64'(idle_o));
    if (hold_prev) begin
      check_value("hold_valid", 64'd1, 64'(pe_req_valid_o));
      check_value("hold_stable", 64'(held_req), 64'(pe_req_o));
    end
    r = next_rand();
    if (!req_hold) begin
      req_i.unit    = unit_e'(r[1:0]);
      req_i.vd      = vreg_t'(r[4:2]);
      req_i.vs1     = vreg_t'(r[7:5]);
      req_i.vs2     = vreg_t'(r[10:8]);
      req_i.use_vd  = r[11];
      req_i.use_vs1 = r[12];
      req_i.use_vs2 = r[13];
      req_valid_i   = !drain && (r[15:14] != 2'b00);
    end
    pe_ready_i = drain || (r[17:16] != 2'b00);
    // Units only finish what they already took
    done = '0;
    for (int u = 0; u < NrUnits; u++) begin
      r    = next_rand();
      cand = m_run[u];
      if (m_out_valid) begin
        cand[m_out_req.id] = 1'b0;
      end
      if (drain || (r % 3 == 0)) begin
        done[u] = pick_done(cand, r >> 2);
      end
    end
    unit_done_i = done;
    #(CLK_PERIOD / 2);
    pred_ready = predict_ready(req_i, pe_ready_i);
    check_value("req_ready", 64'(pred_ready), 64'(req_ready_o));
    if (ids_full()) begin
      check_value("ready_ids_full", 64'd0, 64'(req_ready_o));
    end
    // Units take the held request at the coming edge
    if (pe_req_valid_o && pe_ready_i) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Error: the units took a request that was never accepted");
      end else begin
        check_value("delivery_order", 64'(exp_q.pop_front()), 64'(pe_req_o));
      end
    end
    hold_prev = pe_req_valid_o && !pe_ready_i;
    held_req  = pe_req_o;
    accept    = req_valid_i && pred_ready;
    if (accept) begin
      exp_q.push_back(predict_issue(req_i));
    end
    commit_edge(accept, req_i, pe_ready_i, unit_done_i);
    req_hold = req_valid_i && !pred_ready;
  endtask

  initial begin : p_main
    int unsigned drain_cnt;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    req_i       = '0;
    req_valid_i = 1'b0;
    pe_ready_i  = 1'b0;
    unit_done_i = '0;
    rng_state   = 32'hc495_00be;
    errors      = 0;
    checks      = 0;
    req_hold    = 1'b0;
    hold_prev   = 1'b0;
    held_req    = '0;
    drain_cnt   = 0;
    clear_model();
    repeat (RESET_CYCLES) @(posedge clk_i);
    #(DRIVE_DELAY);
    rst_ni = 1'b1;
    #(DRIVE_DELAY);
    // Quiet state out of reset
    check_value("reset_idle", 64'd1, 64'(idle_o));
    check_value("reset_req_ready", 64'd1, 64'(req_ready_o));
    check_value("reset_pe_valid", 64'd0, 64'(pe_req_valid_o));
    repeat (NUM_CYCLES) run_cycle(1'b0);
    // No new requests, units always ready, everything running retires
    while ((!idle_o || req_valid_i) && (drain_cnt < DRAIN_CYCLES)) begin
      run_cycle(1'b1);
      drain_cnt++;
    end
    if (!idle_o) begin
      errors++;
      $display("Error: idle_o did not return high after all IDs were retired");
    end
    check_value("drain_pending", 64'd0, 64'(exp_q.size()));
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Stimulus plus drain plus margin, one clock period each
  initial begin : p_watchdog
    #((RESET_CYCLES + NUM_CYCLES + DRAIN_CYCLES + 20) * CLK_PERIOD);
    $display("Timeout: the run did not finish in the expected number of cycles");
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- vseq_top.f
+incdir+test
common/vseq_pkg.sv
design/vinsn_tracker.sv
design/unit_credit.sv
scoreboard/vreg_scoreboard.sv
design/issue_ctrl.sv
design/vseq_top.sv
test/tb_vseq_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the sequencer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module tb_vseq_top \
    -f vseq_top.f -Mdir obj_dir -o sim_vseq; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/sim_vseq > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation ended with an error status"
  exit 1
fi

cat "$LOG"
if grep -qx "TEST PASS" "$LOG"; then
  exit 0
fi
exit 1
